//--- build.f
msu_pkg.sv
msu_bus_sync.sv
msu_mcu_sync.sv
msu_databuf.sv
msu_regs.sv
msu_top.sv
msu_sva.sv
tb_msu.sv

//--- msu_bus_sync.sv
`timescale 1ns/1ns

module msu_bus_sync import msu_pkg::*; (
  input  logic         clkin,
  input  logic         rst,
  input  logic         enable,
  input  logic         reg_oe,
  input  logic         reg_we,
  input  msu_reg_idx_t reg_addr,
  input  msu_byte_t    reg_data_in,
  output bus_ev_t      bus_ev
);

  // Strobes travel as {we, oe}
  logic [1:0]   strb_meta;
  logic [1:0]   strb_sync;
  logic [1:0]   strb_prev;
  msu_reg_idx_t addr_meta;
  msu_byte_t    data_meta;
  msu_reg_idx_t addr_hold;
  msu_byte_t    data_hold;
  msu_reg_idx_t addr_ev;
  msu_byte_t    data_ev;
  logic         oe_rise_q;
  logic         oe_fall_q;
  logic         we_rise_q;

  ////////////////////////////////////////////////////////////
  // Strobe synchroniser and edge detect
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (rst) begin
      strb_meta <= '0;
      strb_sync <= '0;
      strb_prev <= '0;
      oe_rise_q <= 1'b0;
      oe_fall_q <= 1'b0;
      we_rise_q <= 1'b0;
    end else begin
      strb_meta <= {reg_we, reg_oe};
      strb_sync <= strb_meta;
      strb_prev <= strb_sync;
      oe_rise_q <= enable & strb_sync[0] & ~strb_prev[0];
      oe_fall_q <= enable & ~strb_sync[0] & strb_prev[0];
      we_rise_q <= enable & strb_sync[1] & ~strb_prev[1];
    end
  end

  // Address and data are sampled together with the strobes and only
  // kept from samples where a strobe was seen high
  always_ff @(posedge clkin) begin
    addr_meta <= reg_addr;
    data_meta <= reg_data_in;
    if (|strb_meta) begin
      addr_hold <= addr_meta;
      data_hold <= data_meta;
    end
    addr_ev <= addr_hold;  // Lines up with the event pulse
    data_ev <= data_hold;
  end

  assign bus_ev = '{oe_rise: oe_rise_q,
                    oe_fall: oe_fall_q,
                    we_rise: we_rise_q,
                    reg_idx: addr_ev,
                    data:    data_ev};

endmodule

//--- msu_databuf.sv
`timescale 1ns/1ns

module msu_databuf import msu_pkg::*; #(
  parameter int ADDR_W = 14
) (
  input  logic              clkin,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  msu_byte_t         wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output msu_byte_t         rd_data
);

  localparam int DEPTH = 2 ** ADDR_W;

  ////////////////////////////////////////////////////////////
  // Simple dual-port block RAM
  ////////////////////////////////////////////////////////////
  msu_byte_t mem [DEPTH];

  // Loader side
  always_ff @(posedge clkin) begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // Data port side, one cycle read latency
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- msu_mcu_sync.sv
`timescale 1ns/1ns

module msu_mcu_sync import msu_pkg::*; #(
  parameter int ADDR_W = 14
) (
  input  logic              clkin,
  input  logic              rst,
  input  logic              status_we,
  input  status_bits_t      status_set,
  input  status_bits_t      status_reset,
  input  logic              addr_ext_we,
  input  logic [ADDR_W-1:0] addr_ext,
  output mcu_ev_t           mcu_ev
);

  // Strobes travel as {addr_ext_we, status_we}
  logic [1:0]    strb_meta;
  logic [1:0]    strb_sync;
  logic [1:0]    strb_prev;
  logic [1:0]    strb_rise;
  logic          status_upd_q;
  logic          addr_load_q;
  status_bits_t  set_q;
  status_bits_t  reset_q;
  msu_ext_addr_t addr_q;

  assign strb_rise = strb_sync & ~strb_prev;

  always_ff @(posedge clkin) begin
    if (rst) begin
      strb_meta    <= '0;
      strb_sync    <= '0;
      strb_prev    <= '0;
      status_upd_q <= 1'b0;
      addr_load_q  <= 1'b0;
    end else begin
      strb_meta    <= {addr_ext_we, status_we};
      strb_sync    <= strb_meta;
      strb_prev    <= strb_sync;
      status_upd_q <= strb_rise[0];
      addr_load_q  <= strb_rise[1];
    end
  end

  // Payload is stable while its strobe is high, grab it on the detecting edge
  always_ff @(posedge clkin) begin
    if (strb_rise[0]) begin
      set_q   <= status_set;
      reset_q <= status_reset;
    end
    if (strb_rise[1])
      addr_q <= msu_ext_addr_t'(addr_ext);  // Zero extended
  end

  assign mcu_ev = '{status_upd: status_upd_q,
                    set_bits:   set_q,
                    reset_bits: reset_q,
                    addr_load:  addr_load_q,
                    addr:       addr_q};

endmodule

//--- msu_pkg.sv
package msu_pkg;

  ////////////////////////////////////////////////////////////
  // Basic widths
  ////////////////////////////////////////////////////////////
  typedef logic [7:0]  msu_byte_t;      // Console bus byte
  typedef logic [2:0]  msu_reg_idx_t;   // Register select on the console bus
  typedef logic [31:0] msu_seek_t;      // Data seek address to the MCU
  typedef logic [15:0] msu_track_t;     // Audio track number
  typedef logic [5:0]  status_bits_t;   // Status set/reset field from the MCU

  // Room for the external buffer address, ADDR_W must not exceed this
  localparam int MSU_EXT_ADDR_W = 16;
  typedef logic [MSU_EXT_ADDR_W-1:0] msu_ext_addr_t;

  ////////////////////////////////////////////////////////////
  // Console register map
  ////////////////////////////////////////////////////////////
  // Read side
  localparam msu_reg_idx_t REG_STATUS     = 3'd0;
  localparam msu_reg_idx_t REG_DATA       = 3'd1;  // Buffer read port
  // Write side
  localparam msu_reg_idx_t REG_DATA_ADDR0 = 3'd0;  // Seek bits 7:0
  localparam msu_reg_idx_t REG_DATA_ADDR1 = 3'd1;
  localparam msu_reg_idx_t REG_DATA_ADDR2 = 3'd2;
  localparam msu_reg_idx_t REG_DATA_ADDR3 = 3'd3;  // Seek bits 31:24, starts the seek
  localparam msu_reg_idx_t REG_TRACK0     = 3'd4;
  localparam msu_reg_idx_t REG_TRACK1     = 3'd5;  // Starts the track load
  localparam msu_reg_idx_t REG_VOLUME     = 3'd6;
  localparam msu_reg_idx_t REG_CTRL       = 3'd7;

  // Status field bit positions
  localparam int ST_AUDIO_BUSY   = 5;
  localparam int ST_DATA_BUSY    = 4;
  localparam int ST_AUDIO_ERROR  = 3;
  localparam int ST_AUDIO_STATUS = 1;  // Two bits, 2:1
  localparam int ST_CTRL_START   = 0;

  // "S-MSU1", indexed by register number 2 to 7
  localparam logic [2:7][7:0] MSU_ID = 48'h53_2D_4D_53_55_31;
  localparam logic [2:0] STATUS_REV = 3'b010;

  ////////////////////////////////////////////////////////////
  // Event bundles between the stages
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic         oe_rise;
    logic         oe_fall;
    logic         we_rise;
    msu_reg_idx_t reg_idx;
    msu_byte_t    data;
  } bus_ev_t;

  typedef struct packed {
    logic          status_upd;
    status_bits_t  set_bits;
    status_bits_t  reset_bits;
    logic          addr_load;
    msu_ext_addr_t addr;
  } mcu_ev_t;

endpackage

//--- msu_regs.sv
`timescale 1ns/1ns

module msu_regs import msu_pkg::*; #(
  parameter int ADDR_W = 14
) (
  input  logic              clkin,
  input  logic              rst,
  input  bus_ev_t           bus_ev,
  input  mcu_ev_t           mcu_ev,
  output logic [ADDR_W-1:0] buf_addr,
  input  msu_byte_t         buf_data,
  output msu_byte_t         reg_data_out,
  output msu_byte_t         status_out,
  output msu_seek_t         seek_addr,
  output msu_track_t        track,
  output msu_byte_t         volume,
  output logic              volume_latch
);

  logic         audio_start;
  logic         audio_busy;
  logic         data_start;
  logic         data_busy;
  logic         ctrl_start;
  logic         audio_error;
  logic [2:0]   audio_ctrl;
  logic [1:0]   audio_status;
  status_bits_t st_set;
  status_bits_t st_clr;
  msu_byte_t    status_rd;
  msu_byte_t    rd_mux;

  assign st_set = mcu_ev.set_bits;
  assign st_clr = mcu_ev.reset_bits;

  ////////////////////////////////////////////////////////////
  // Data port address
  ////////////////////////////////////////////////////////////
  // External load from the MCU wins over the read increment
  always_ff @(posedge clkin) begin
    if (rst)
      buf_addr <= '0;
    else if (mcu_ev.addr_load)
      buf_addr <= mcu_ev.addr[ADDR_W-1:0];
    else if (bus_ev.oe_rise && bus_ev.reg_idx == REG_DATA)
      buf_addr <= buf_addr + 1'b1;  // Advance at the start of each data read
  end

  ////////////////////////////////////////////////////////////
  // Console read path
  ////////////////////////////////////////////////////////////
  assign status_rd = {data_busy, audio_busy, audio_status, audio_error, STATUS_REV};

  always_comb begin
    case (bus_ev.reg_idx)
      REG_STATUS: rd_mux = status_rd;
      REG_DATA:   rd_mux = buf_data;
      default:    rd_mux = MSU_ID[bus_ev.reg_idx];  // ID string
    endcase
  end

  // Read data is latched when the console strobe ends
  always_ff @(posedge clkin) begin
    if (bus_ev.oe_fall)
      reg_data_out <= rd_mux;
  end

  ////////////////////////////////////////////////////////////
  // Requests and status flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (rst) begin
      seek_addr    <= '0;
      track        <= '0;
      volume       <= '0;
      volume_latch <= 1'b0;
      data_start   <= 1'b0;
      audio_start  <= 1'b0;
      ctrl_start   <= 1'b0;
      audio_error  <= 1'b0;
      audio_ctrl   <= '0;
      audio_status <= '0;
      data_busy    <= 1'b1;  // Busy until the MCU reports ready
      audio_busy   <= 1'b1;
    end else begin
      volume_latch <= 1'b0;
      if (bus_ev.we_rise) begin
        // Console write, a status update in the same cycle is dropped
        case (bus_ev.reg_idx)
          REG_DATA_ADDR0: seek_addr[7:0]   <= bus_ev.data;
          REG_DATA_ADDR1: seek_addr[15:8]  <= bus_ev.data;
          REG_DATA_ADDR2: seek_addr[23:16] <= bus_ev.data;
          REG_DATA_ADDR3: begin
            seek_addr[31:24] <= bus_ev.data;
            data_start       <= 1'b1;
            data_busy        <= 1'b1;
          end
          REG_TRACK0: track[7:0] <= bus_ev.data;
          REG_TRACK1: begin
            track[15:8] <= bus_ev.data;
            audio_start <= 1'b1;
            audio_busy  <= 1'b1;
          end
          REG_VOLUME: begin
            volume       <= bus_ev.data;
            volume_latch <= 1'b1;  // Single cycle
          end
          REG_CTRL: begin
            if (!audio_busy) begin  // Ignored while a track is loading
              audio_ctrl <= bus_ev.data[2:0];
              ctrl_start <= 1'b1;
            end
          end
          default: ;
        endcase
      end else if (mcu_ev.status_upd) begin
        // Set first, then clear
        audio_busy <= (audio_busy | st_set[ST_AUDIO_BUSY]) & ~st_clr[ST_AUDIO_BUSY];
        if (st_clr[ST_AUDIO_BUSY])
          audio_start <= 1'b0;
        data_busy <= (data_busy | st_set[ST_DATA_BUSY]) & ~st_clr[ST_DATA_BUSY];
        if (st_clr[ST_DATA_BUSY])
          data_start <= 1'b0;
        audio_error <= (audio_error | st_set[ST_AUDIO_ERROR]) & ~st_clr[ST_AUDIO_ERROR];
        audio_status <= (audio_status | st_set[ST_AUDIO_STATUS +: 2])
                        & ~st_clr[ST_AUDIO_STATUS +: 2];
        ctrl_start <= (ctrl_start | st_set[ST_CTRL_START]) & ~st_clr[ST_CTRL_START];
      end
    end
  end

  // Flags seen by the MCU
  assign status_out = {buf_addr[ADDR_W-1],  // 7
                       audio_start,         // 6
                       data_start,          // 5
                       volume_latch,        // 4
                       audio_ctrl,          // 3:1
                       ctrl_start};         // 0

endmodule

//--- msu_sva.sv
`timescale 1ns/1ns

module msu_sva import msu_pkg::*; (
  input logic         clkin,
  input logic         rst,
  input logic         enable,
  input logic         reg_oe,
  input logic         reg_we,
  input msu_reg_idx_t reg_addr,
  input msu_byte_t    reg_data_out,
  input msu_byte_t    status_out,
  input logic         volume_latch
);

  int fail_count = 0;

  ////////////////////////////////////////////////////////////
  // Register behaviour at the top-level ports
  ////////////////////////////////////////////////////////////
  a_latch_pulse: assert property (@(posedge clkin) disable iff (rst)
    volume_latch |=> !volume_latch)
    else begin
      fail_count++;
      $error("volume_latch stayed high for more than one cycle");
    end

  // Strobe end to latched read data is four edges
  a_id_read: assert property (@(posedge clkin) disable iff (rst)
    $fell(reg_oe) && enable && reg_addr >= REG_DATA_ADDR2
      |-> ##4 reg_data_out == MSU_ID[$past(reg_addr, 4)])
    else begin
      fail_count++;
      $error("reg_data_out does not match the ID byte of the register read");
    end

  a_data_start: assert property (@(posedge clkin) disable iff (rst)
    $rose(reg_we) && enable && reg_addr == REG_DATA_ADDR3 |-> ##4 status_out[5])
    else begin
      fail_count++;
      $error("Data start flag not raised after a write to register 3");
    end

  a_audio_start: assert property (@(posedge clkin) disable iff (rst)
    $rose(reg_we) && enable && reg_addr == REG_TRACK1 |-> ##4 status_out[6])
    else begin
      fail_count++;
      $error("Audio start flag not raised after a write to register 5");
    end

endmodule

bind msu_top msu_sva sva_inst (
  .clkin        (clkin),
  .rst          (rst),
  .enable       (enable),
  .reg_oe       (reg_oe),
  .reg_we       (reg_we),
  .reg_addr     (reg_addr),
  .reg_data_out (reg_data_out),
  .status_out   (status_out),
  .volume_latch (volume_latch)
);

//--- msu_top.sv
`timescale 1ns/1ns

module msu_top import msu_pkg::*; #(
  parameter int ADDR_W = 14
) (
  input  logic              clkin,
  input  logic              rst,
  input  logic              enable,
  // Console bus
  input  logic              reg_oe,
  input  logic              reg_we,
  input  msu_reg_idx_t      reg_addr,
  input  msu_byte_t         reg_data_in,
  output msu_byte_t         reg_data_out,
  // Buffer loader
  input  logic              pgm_we,
  input  logic [ADDR_W-1:0] pgm_addr,
  input  msu_byte_t         pgm_data,
  // MCU side
  input  logic              status_we,
  input  status_bits_t      status_set,
  input  status_bits_t      status_reset,
  input  logic              addr_ext_we,
  input  logic [ADDR_W-1:0] addr_ext,
  output msu_byte_t         status_out,
  output msu_seek_t         seek_addr,
  output msu_track_t        track,
  output msu_byte_t         volume,
  output logic              volume_latch
);

  bus_ev_t           bus_ev;
  mcu_ev_t           mcu_ev;
  logic [ADDR_W-1:0] buf_addr;
  msu_byte_t         buf_data;

  ////////////////////////////////////////////////////////////
  // Input sync stages
  ////////////////////////////////////////////////////////////
  msu_bus_sync bus_sync_inst (
    .clkin       (clkin),
    .rst         (rst),
    .enable      (enable),
    .reg_oe      (reg_oe),
    .reg_we      (reg_we),
    .reg_addr    (reg_addr),
    .reg_data_in (reg_data_in),
    .bus_ev      (bus_ev)
  );

  msu_mcu_sync #(.ADDR_W(ADDR_W)) mcu_sync_inst (
    .clkin        (clkin),
    .rst          (rst),
    .status_we    (status_we),
    .status_set   (status_set),
    .status_reset (status_reset),
    .addr_ext_we  (addr_ext_we),
    .addr_ext     (addr_ext),
    .mcu_ev       (mcu_ev)
  );

  ////////////////////////////////////////////////////////////
  // Register stage and data buffer
  ////////////////////////////////////////////////////////////
  msu_regs #(.ADDR_W(ADDR_W)) regs_inst (
    .clkin        (clkin),
    .rst          (rst),
    .bus_ev       (bus_ev),
    .mcu_ev       (mcu_ev),
    .buf_addr     (buf_addr),
    .buf_data     (buf_data),
    .reg_data_out (reg_data_out),
    .status_out   (status_out),
    .seek_addr    (seek_addr),
    .track        (track),
    .volume       (volume),
    .volume_latch (volume_latch)
  );

  msu_databuf #(.ADDR_W(ADDR_W)) databuf_inst (
    .clkin   (clkin),
    .wr_en   (pgm_we),  // Active high loader strobe
    .wr_addr (pgm_addr),
    .wr_data (pgm_data),
    .rd_addr (buf_addr),
    .rd_data (buf_data)
  );

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tb_msu -o tb_msu_sim &&
./obj_dir/tb_msu_sim +verilator+error+limit+100 | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- tb_msu.sv
`timescale 1ns/1ns

module tb_msu import msu_pkg::*; ();

  localparam int ADDR_W = 14;

  logic              clkin = 1'b0;
  logic              rst;
  logic              enable;
  logic              reg_oe;
  logic              reg_we;
  msu_reg_idx_t      reg_addr;
  msu_byte_t         reg_data_in;
  msu_byte_t         reg_data_out;
  logic              pgm_we;
  logic [ADDR_W-1:0] pgm_addr;
  msu_byte_t         pgm_data;
  logic              status_we;
  status_bits_t      status_set;
  status_bits_t      status_reset;
  logic              addr_ext_we;
  logic [ADDR_W-1:0] addr_ext;
  msu_byte_t         status_out;
  msu_seek_t         seek_addr;
  msu_track_t        track;
  msu_byte_t         volume;
  logic              volume_latch;

  int                errors = 0;
  int                checks = 0;
  int                tests = 0;
  int                test_start = 0;
  int                latch_count = 0;
  int                latch_seen;
  msu_byte_t         rd;
  msu_byte_t         bytes [8];
  logic [5:0]        flags;  // Model of the MCU status field
  logic [ADDR_W-1:0] base;
  msu_seek_t         seek_old;
  msu_track_t        track_old;
  msu_byte_t         volume_old;
  string             id_text = "S-MSU1";

  always #5 clkin = ~clkin;

  always @(posedge clkin) begin
    if (!rst && volume_latch)
      latch_count <= latch_count + 1;
  end

  msu_top #(.ADDR_W(ADDR_W)) msu_top_inst (.*);

  ////////////////////////////////////////////////////////////
  // Bus and MCU drivers
  ////////////////////////////////////////////////////////////
  task automatic tick(input int n);
    repeat (n) @(posedge clkin);
    #1;  // Drive point
  endtask

  task automatic bus_read(input msu_reg_idx_t idx, output msu_byte_t data);
    reg_addr = idx;
    reg_oe = 1'b1;
    tick(8);
    reg_oe = 1'b0;
    tick(6);  // Latched four edges after the strobe ends
    data = reg_data_out;
  endtask

  task automatic bus_write(input msu_reg_idx_t idx, input msu_byte_t data);
    reg_addr = idx;
    reg_data_in = data;
    reg_we = 1'b1;
    tick(8);
    reg_we = 1'b0;
    tick(6);
  endtask

  task automatic mcu_status(input status_bits_t set_bits, input status_bits_t clr_bits);
    status_set = set_bits;
    status_reset = clr_bits;
    status_we = 1'b1;
    tick(8);
    status_we = 1'b0;
    tick(6);
    flags = (flags | set_bits) & ~clr_bits;  // Set first, then clear
  endtask

  task automatic load_address(input logic [ADDR_W-1:0] addr);
    addr_ext = addr;
    addr_ext_we = 1'b1;
    tick(8);
    addr_ext_we = 1'b0;
    tick(6);
  endtask

  // Register 0 layout from the model
  function automatic msu_byte_t status_read();
    return {flags[4], flags[5], flags[2:1], flags[3], 3'b010};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic wait_status_bit(input int bit_pos, input logic val);
    int n;
    n = 0;
    while (status_out[bit_pos] !== val && n < 40) begin
      tick(1);
      n++;
    end
    checks++;
    assert (status_out[bit_pos] === val) else begin
      errors++;
      $display("Timeout at %0t ns: status_out bit %0d never became %b", $time, bit_pos, val);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s finished with %0d errors", tests, name, errors - test_start);
    test_start = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    rst = 1'b1;
    enable = 1'b1;
    reg_oe = 1'b0;
    reg_we = 1'b0;
    reg_addr = '0;
    reg_data_in = '0;
    pgm_we = 1'b0;
    pgm_addr = '0;
    pgm_data = '0;
    status_we = 1'b0;
    status_set = '0;
    status_reset = '0;
    addr_ext_we = 1'b0;
    addr_ext = '0;
    void'($urandom(32'h6046));
    repeat (10) @(posedge clkin);
    #1;
    rst = 1'b0;
    flags = 6'b110000;  // Both busy out of reset
    tick(2);

    for (int i = 2; i < 8; i++) begin
      bus_read(3'(i), rd);
      check_value("reg_data_out", 32'(id_text[i-2]), 32'(rd));
    end
    end_test("id string");

    // Pointer advances before the fetch, so data starts one past the loaded address
    base = ADDR_W'($urandom);
    for (int k = 0; k < 8; k++) begin
      bytes[k] = 8'($urandom);
      pgm_addr = base + ADDR_W'(k + 1);
      pgm_data = bytes[k];
      pgm_we = 1'b1;
      tick(1);
    end
    pgm_we = 1'b0;
    load_address(base);
    for (int k = 0; k < 8; k++) begin
      bus_read(REG_DATA, rd);
      check_value("reg_data_out", 32'(bytes[k]), 32'(rd));
    end
    base = base + ADDR_W'(8);  // One increment per read
    check_value("status_out[7]", 32'(base[ADDR_W-1]), 32'(status_out[7]));
    end_test("data port");

    // Both busy flags cleared first so the writes have to set them
    mcu_status(6'b000000, 6'b110000);
    for (int k = 0; k < 6; k++)
      bytes[k] = 8'($urandom);
    for (int k = 0; k < 4; k++)
      bus_write(3'(k), bytes[k]);
    flags[4] = 1'b1;  // Data busy from the register 3 write
    check_value("seek_addr", {bytes[3], bytes[2], bytes[1], bytes[0]}, seek_addr);
    wait_status_bit(5, 1'b1);
    bus_write(REG_TRACK0, bytes[4]);
    bus_write(REG_TRACK1, bytes[5]);
    flags[5] = 1'b1;  // Audio busy from the register 5 write
    check_value("track", 32'({bytes[5], bytes[4]}), 32'(track));
    wait_status_bit(6, 1'b1);
    bus_read(REG_STATUS, rd);
    check_value("reg_data_out", 32'(status_read()), 32'(rd));
    end_test("requests");

    latch_seen = latch_count;
    bytes[0] = 8'($urandom);
    bus_write(REG_VOLUME, bytes[0]);
    check_value("volume", 32'(bytes[0]), 32'(volume));
    check_value("volume_latch pulses", 32'(latch_seen + 1), 32'(latch_count));
    end_test("volume");

    for (int k = 0; k < 6; k++) begin
      mcu_status(6'($urandom), 6'($urandom));
      bus_read(REG_STATUS, rd);
      check_value("reg_data_out", 32'(status_read()), 32'(rd));
    end
    mcu_status(6'b100000, 6'b000001);  // Audio busy on, control start off
    bytes[0] = 8'($urandom);
    bus_write(REG_CTRL, bytes[0]);
    check_value("status_out[3:0]", 32'h0, 32'(status_out[3:0]));
    mcu_status(6'b000000, 6'b100000);
    bus_write(REG_CTRL, bytes[0]);
    wait_status_bit(0, 1'b1);
    check_value("status_out[3:0]", 32'({bytes[0][2:0], 1'b1}), 32'(status_out[3:0]));
    end_test("status");

    // Inverted values so any accepted write shows up
    enable = 1'b0;
    seek_old = seek_addr;
    track_old = track;
    volume_old = volume;
    bus_write(REG_DATA_ADDR0, ~seek_old[7:0]);
    bus_write(REG_TRACK0, ~track_old[7:0]);
    bus_write(REG_VOLUME, ~volume_old);
    check_value("seek_addr", seek_old, seek_addr);
    check_value("track", 32'(track_old), 32'(track));
    check_value("volume", 32'(volume_old), 32'(volume));
    enable = 1'b1;
    end_test("enable");

    errors += msu_top_inst.sva_inst.fail_count;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule
